/* sata_consts.svh */
// SATA device PHY constants

`ifndef SATA_CONSTS_SVH
`define SATA_CONSTS_SVH

// ALIGN primitive, sent with K flag on the low byte
`define SATA_PRIM_ALIGN     32'h7B4A4ABC

// SYNC primitive
`define SATA_PRIM_SYNC      32'hB5B5957C

// Host dialtone, plain data with no K flag
`define SATA_DIALTONE       32'h4A4A4A4A

// Cycles allowed for the host to return ALIGN
`define SATA_ALIGN_TIMEOUT  100

// Dwords per align period, the last two are ALIGN
`define SATA_ALIGN_INTERVAL 256

`endif

/* sata_phy_pkg.sv */
// SATA device PHY types

`default_nettype none

package sata_phy_pkg;

    // OOB control states
    typedef enum logic [3:0] {
        SEND_INIT     = 4'h0,
        WAIT_WAKE     = 4'h1,
        WAIT_NO_WAKE  = 4'h2,
        SEND_WAKE     = 4'h3,
        WAIT_DIALTONE = 4'h4,
        SEND_ALIGN    = 4'h5,
        WAIT_ALIGN    = 4'h6,
        READY         = 4'h7,
        OFFLINE       = 4'h8
    } oob_state_t;

    // Transmitter dword source
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_ALIGN = 2'd1,
        TX_LINK  = 2'd2
    } tx_mode_t;

endpackage

`default_nettype wire

/* oob_ctrl.sv */
// OOB handshake control

`timescale 1ns/1ps
`default_nettype none

`include "sata_consts.svh"

module oob_ctrl
    import sata_phy_pkg::*;
(
    input  logic       clk,
    input  logic       comm_reset_detect,
    input  logic       comm_wake_detect,
    input  logic       align_seen,
    input  logic       dialtone_seen,
    output logic       tx_comm_init,
    output logic       tx_comm_wake,
    output logic       tx_set_elec_idle,
    output logic       hd_ready,
    output logic       phy_ready,
    output logic       rx_byte_is_aligned,
    output logic       link_up,
    output tx_mode_t   tx_mode,
    output oob_state_t phy_state
);

    localparam int TMR_W = $clog2(`SATA_ALIGN_TIMEOUT);

    oob_state_t       state;
    logic [TMR_W-1:0] align_tmr;

    // Sequence through the device side of OOB
    always_ff @(posedge clk) begin
        if (comm_reset_detect) begin
            state        <= SEND_INIT;
            align_tmr    <= '0;
            tx_comm_init <= 1'b0;
            tx_comm_wake <= 1'b0;
        end else begin
            tx_comm_init <= 1'b0;
            tx_comm_wake <= 1'b0;
            case (state)
                SEND_INIT: begin
                    // Host released COMRESET, answer with COMINIT
                    tx_comm_init <= 1'b1;
                    state        <= WAIT_WAKE;
                end
                WAIT_WAKE: begin
                    if (comm_wake_detect) begin
                        state <= WAIT_NO_WAKE;
                    end
                end
                WAIT_NO_WAKE: begin
                    if (!comm_wake_detect) begin
                        state <= SEND_WAKE;
                    end
                end
                SEND_WAKE: begin
                    tx_comm_wake <= 1'b1;
                    state        <= WAIT_DIALTONE;
                end
                WAIT_DIALTONE: begin
                    if (dialtone_seen) begin
                        state <= SEND_ALIGN;
                    end
                end
                SEND_ALIGN: begin
                    align_tmr <= TMR_W'(`SATA_ALIGN_TIMEOUT - 1);
                    state     <= WAIT_ALIGN;
                end
                WAIT_ALIGN: begin
                    if (align_seen) begin
                        state <= READY;
                    end else if (align_tmr == '0) begin
                        // Host never answered
                        state <= OFFLINE;
                    end else begin
                        align_tmr <= align_tmr - 1'b1;
                    end
                end
                READY: begin
                    state <= READY;
                end
                OFFLINE: begin
                    // Only a new COMRESET leaves here
                    state <= OFFLINE;
                end
                default: begin
                    state <= OFFLINE;
                end
            endcase
        end
    end

    // Transmitter source follows the state
    always_comb begin
        case (state)
            SEND_ALIGN, WAIT_ALIGN: tx_mode = TX_ALIGN;
            READY:                  tx_mode = TX_LINK;
            default:                tx_mode = TX_IDLE;
        endcase
    end

    // Line status lines up with the registered transmit dword
    always_ff @(posedge clk) begin
        if (comm_reset_detect) begin
            tx_set_elec_idle   <= 1'b1;
            rx_byte_is_aligned <= 1'b0;
            hd_ready           <= 1'b0;
        end else begin
            tx_set_elec_idle   <= (tx_mode == TX_IDLE);
            rx_byte_is_aligned <= (tx_mode != TX_IDLE);
            hd_ready           <= (state == READY);
        end
    end

    assign phy_ready = (state == READY);
    assign link_up   = (state == READY);
    assign phy_state = state;

endmodule

`default_nettype wire

/* rx_prim_detect.sv */
// Receive primitive detection

`timescale 1ns/1ps
`default_nettype none

`include "sata_consts.svh"

module rx_prim_detect (
    input  logic        clk,
    input  logic        comm_reset_detect,
    input  logic [31:0] rx_din,
    input  logic [3:0]  rx_isk,
    input  logic        link_up,
    input  logic        rx_ack,
    output logic        align_seen,
    output logic        dialtone_seen,
    output logic        rx_req,
    output logic [31:0] rx_prim_data,
    output logic [3:0]  rx_prim_isk,
    output logic        rx_overflow
);

    logic [31:0] din_q;
    logic [3:0]  isk_q;
    logic        is_align;
    logic        is_dialtone;
    logic        is_other;
    logic        other_q;
    logic        offer;
    logic        port_busy;

    // Classify the incoming dword
    assign is_align    = (|rx_isk) && (rx_din == `SATA_PRIM_ALIGN);
    assign is_dialtone = (rx_isk == 4'h0) && (rx_din == `SATA_DIALTONE);
    assign is_other    = (|rx_isk) && !is_align && (rx_din != `SATA_PRIM_SYNC);

    always_ff @(posedge clk) begin
        if (comm_reset_detect) begin
            align_seen    <= 1'b0;
            dialtone_seen <= 1'b0;
            other_q       <= 1'b0;
        end else begin
            align_seen    <= is_align;
            dialtone_seen <= is_dialtone;
            other_q       <= is_other;
        end
    end

    always_ff @(posedge clk) begin
        din_q <= rx_din;
        isk_q <= rx_isk;
    end

    // Port stays busy until the link layer drops rx_ack
    assign port_busy = rx_req || rx_ack;
    assign offer     = link_up && other_q;

    always_ff @(posedge clk) begin
        if (comm_reset_detect) begin
            rx_req      <= 1'b0;
            rx_overflow <= 1'b0;
        end else begin
            if (rx_req && rx_ack) begin
                rx_req <= 1'b0;
            end
            if (offer) begin
                if (port_busy) begin
                    rx_overflow <= 1'b1;
                end else begin
                    rx_req <= 1'b1;
                end
            end
        end
    end

    // Holding register for the offered primitive
    always_ff @(posedge clk) begin
        if (offer && !port_busy) begin
            rx_prim_data <= din_q;
            rx_prim_isk  <= isk_q;
        end
    end

endmodule

`default_nettype wire

/* tx_prim_gen.sv */
// Transmit dword generator

`timescale 1ns/1ps
`default_nettype none

`include "sata_consts.svh"

module tx_prim_gen
    import sata_phy_pkg::*;
(
    input  logic        clk,
    input  logic        comm_reset_detect,
    input  tx_mode_t    tx_mode,
    input  logic        tx_req,
    input  logic [31:0] tx_link_data,
    input  logic        tx_link_isk,
    output logic        tx_ack,
    output logic [31:0] tx_dout,
    output logic        tx_isk
);

    localparam int CNT_W = $clog2(`SATA_ALIGN_INTERVAL);

    logic [CNT_W-1:0] align_cnt;
    logic             align_slot;
    logic             take_link;

    // Last two dwords of every period carry ALIGN
    assign align_slot = (align_cnt >= CNT_W'(`SATA_ALIGN_INTERVAL - 2));

    // Pending link dword goes out in any non-ALIGN slot
    assign take_link = (tx_mode == TX_LINK) && !align_slot && tx_req && !tx_ack;

    // Align period counter, restarts on each entry to link mode
    always_ff @(posedge clk) begin
        if (comm_reset_detect) begin
            align_cnt <= '0;
        end else if (tx_mode != TX_LINK) begin
            align_cnt <= '0;
        end else if (align_cnt == CNT_W'(`SATA_ALIGN_INTERVAL - 1)) begin
            align_cnt <= '0;
        end else begin
            align_cnt <= align_cnt + 1'b1;
        end
    end

    // Responder side of the link handshake
    always_ff @(posedge clk) begin
        if (comm_reset_detect) begin
            tx_ack <= 1'b0;
        end else if (take_link) begin
            tx_ack <= 1'b1;
        end else if (!tx_req) begin
            tx_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (comm_reset_detect) begin
            tx_dout <= 32'h0;
            tx_isk  <= 1'b0;
        end else begin
            case (tx_mode)
                TX_ALIGN: begin
                    tx_dout <= `SATA_PRIM_ALIGN;
                    tx_isk  <= 1'b1;
                end
                TX_LINK: begin
                    if (align_slot) begin
                        tx_dout <= `SATA_PRIM_ALIGN;
                        tx_isk  <= 1'b1;
                    end else if (take_link) begin
                        tx_dout <= tx_link_data;
                        tx_isk  <= tx_link_isk;
                    end else begin
                        // Idle link fill
                        tx_dout <= `SATA_PRIM_SYNC;
                        tx_isk  <= 1'b1;
                    end
                end
                default: begin
                    tx_dout <= 32'h0;
                    tx_isk  <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* faux_sata_dev_phy.sv */
// Simulated SATA device PHY

`timescale 1ns/1ps
`default_nettype none

module faux_sata_dev_phy
    import sata_phy_pkg::*;
(
    input  logic        clk,
    input  logic        comm_reset_detect,
    input  logic        comm_wake_detect,
    input  logic [31:0] rx_din,
    input  logic [3:0]  rx_isk,
    input  logic        tx_req,
    input  logic [31:0] tx_link_data,
    input  logic        tx_link_isk,
    input  logic        rx_ack,
    output logic [31:0] tx_dout,
    output logic        tx_isk,
    output logic        tx_set_elec_idle,
    output logic        tx_comm_init,
    output logic        tx_comm_wake,
    output logic        rx_byte_is_aligned,
    output logic        hd_ready,
    output logic        phy_ready,
    output oob_state_t  phy_state,
    output logic        tx_ack,
    output logic        rx_req,
    output logic [31:0] rx_prim_data,
    output logic [3:0]  rx_prim_isk,
    output logic        rx_overflow
);

    logic     align_seen;
    logic     dialtone_seen;
    logic     link_up;
    tx_mode_t tx_mode;

    oob_ctrl u_oob_ctrl (
        .clk                (clk),
        .comm_reset_detect  (comm_reset_detect),
        .comm_wake_detect   (comm_wake_detect),
        .align_seen         (align_seen),
        .dialtone_seen      (dialtone_seen),
        .tx_comm_init       (tx_comm_init),
        .tx_comm_wake       (tx_comm_wake),
        .tx_set_elec_idle   (tx_set_elec_idle),
        .hd_ready           (hd_ready),
        .phy_ready          (phy_ready),
        .rx_byte_is_aligned (rx_byte_is_aligned),
        .link_up            (link_up),
        .tx_mode            (tx_mode),
        .phy_state          (phy_state)
    );

    rx_prim_detect u_rx_prim_detect (
        .clk               (clk),
        .comm_reset_detect (comm_reset_detect),
        .rx_din            (rx_din),
        .rx_isk            (rx_isk),
        .link_up           (link_up),
        .rx_ack            (rx_ack),
        .align_seen        (align_seen),
        .dialtone_seen     (dialtone_seen),
        .rx_req            (rx_req),
        .rx_prim_data      (rx_prim_data),
        .rx_prim_isk       (rx_prim_isk),
        .rx_overflow       (rx_overflow)
    );

    tx_prim_gen u_tx_prim_gen (
        .clk               (clk),
        .comm_reset_detect (comm_reset_detect),
        .tx_mode           (tx_mode),
        .tx_req            (tx_req),
        .tx_link_data      (tx_link_data),
        .tx_link_isk       (tx_link_isk),
        .tx_ack            (tx_ack),
        .tx_dout           (tx_dout),
        .tx_isk            (tx_isk)
    );

endmodule

`default_nettype wire

/* tb_faux_sata_dev_phy.sv */
// SATA device PHY testbench

`timescale 1ns/1ps
`default_nettype none

`include "sata_consts.svh"

module tb_faux_sata_dev_phy
    import sata_phy_pkg::*;
;

    localparam int NUM_ROWS   = 6;
    localparam int OOB_STEPS  = 40;
    localparam int ALIGN_INT  = `SATA_ALIGN_INTERVAL;
    localparam int MAX_CYCLES = 2 * (OOB_STEPS + `SATA_ALIGN_TIMEOUT) + 3 * ALIGN_INT
                              + NUM_ROWS * (ALIGN_INT + 32);

    logic        clk;
    logic        comm_reset_detect;
    logic        comm_wake_detect;
    logic [31:0] rx_din;
    logic [3:0]  rx_isk;
    logic        tx_req;
    logic [31:0] tx_link_data;
    logic        tx_link_isk;
    logic        rx_ack;
    logic [31:0] tx_dout;
    logic        tx_isk;
    logic        tx_set_elec_idle;
    logic        tx_comm_init;
    logic        tx_comm_wake;
    logic        rx_byte_is_aligned;
    logic        hd_ready;
    logic        phy_ready;
    oob_state_t  phy_state;
    logic        tx_ack;
    logic        rx_req;
    logic [31:0] rx_prim_data;
    logic [3:0]  rx_prim_isk;
    logic        rx_overflow;

    // Stimulus and expected values per step
    string       row_name    [NUM_ROWS];
    logic [31:0] row_tx_data [NUM_ROWS];
    logic        row_tx_isk  [NUM_ROWS];
    logic        row_in_align[NUM_ROWS];
    logic [31:0] row_rx_data [NUM_ROWS];
    logic [3:0]  row_rx_isk  [NUM_ROWS];
    logic        row_rx_offer[NUM_ROWS];

    int          error_count;
    int          cycle_cnt;
    string       cur_test;
    logic [31:0] lfsr_state;

    // Transmit stream model
    // Slot stays at -1 until the link is up
    int          slot;
    logic        req_pending;
    logic        link_sent;
    logic [31:0] link_exp_data;
    logic        link_exp_isk;

    faux_sata_dev_phy UUT (
        .clk                (clk),
        .comm_reset_detect  (comm_reset_detect),
        .comm_wake_detect   (comm_wake_detect),
        .rx_din             (rx_din),
        .rx_isk             (rx_isk),
        .tx_req             (tx_req),
        .tx_link_data       (tx_link_data),
        .tx_link_isk        (tx_link_isk),
        .rx_ack             (rx_ack),
        .tx_dout            (tx_dout),
        .tx_isk             (tx_isk),
        .tx_set_elec_idle   (tx_set_elec_idle),
        .tx_comm_init       (tx_comm_init),
        .tx_comm_wake       (tx_comm_wake),
        .rx_byte_is_aligned (rx_byte_is_aligned),
        .hd_ready           (hd_ready),
        .phy_ready          (phy_ready),
        .phy_state          (phy_state),
        .tx_ack             (tx_ack),
        .rx_req             (rx_req),
        .rx_prim_data       (rx_prim_data),
        .rx_prim_isk        (rx_prim_isk),
        .rx_overflow        (rx_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog
    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt > MAX_CYCLES) begin
                $display("Run stopped after %0d cycles with %0d errors", cycle_cnt, error_count);
                $display("Errors found");
                $finish;
            end
        end
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic take_random(input int nbits, output logic [31:0] val);
        val = '0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
        error_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("Failure in %s: %s", cur_test, msg);
        error_count++;
    endtask

    // Advance one clock and check the transmit dword against the stream model
    task automatic tick;
        logic [31:0] exp_word;
        logic        exp_k;
        @(posedge clk);
        #2;
        if (slot >= 0) begin
            if ((slot % ALIGN_INT) >= ALIGN_INT - 2) begin
                exp_word = `SATA_PRIM_ALIGN;
                exp_k    = 1'b1;
            end else if (req_pending) begin
                exp_word    = link_exp_data;
                exp_k       = link_exp_isk;
                req_pending = 1'b0;
                link_sent   = 1'b1;
                if (tx_ack !== 1'b1) report_mismatch("tx_ack with dword", 1, tx_ack);
            end else begin
                exp_word = `SATA_PRIM_SYNC;
                exp_k    = 1'b1;
            end
            if (tx_dout !== exp_word) report_mismatch("tx_dout", exp_word, tx_dout);
            if (tx_isk !== exp_k) report_mismatch("tx_isk", exp_k, tx_isk);
            slot++;
        end
    endtask

    task automatic build_table;
        logic [31:0] r;
        row_name = '{"link_data", "link_k_word", "align_slot_req", "rx_data_word",
                     "rx_prim_b", "rx_prim_c"};
        row_in_align = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
        row_rx_data  = '{32'h4A4A957C, `SATA_PRIM_SYNC, `SATA_PRIM_ALIGN, 32'h12345678,
                         32'h3535B57C, 32'h5656B57C};
        row_rx_isk   = '{4'b0001, 4'b0001, 4'b0001, 4'b0000, 4'b0001, 4'b0011};
        row_rx_offer = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
        for (int i = 0; i < NUM_ROWS; i++) begin
            take_random(32, r);
            row_tx_data[i] = r;
            take_random(1, r);
            row_tx_isk[i] = r[0];
        end
    endtask

    task automatic check_reset_outputs;
        if (phy_state !== SEND_INIT) report_mismatch("phy_state", SEND_INIT, phy_state);
        if ({tx_set_elec_idle, tx_comm_init, tx_comm_wake, hd_ready, phy_ready,
             rx_byte_is_aligned, rx_req, rx_overflow, tx_ack, tx_isk} !== 10'b1000000000) begin
            report_mismatch("reset status", 10'b1000000000,
                            {tx_set_elec_idle, tx_comm_init, tx_comm_wake, hd_ready, phy_ready,
                             rx_byte_is_aligned, rx_req, rx_overflow, tx_ack, tx_isk});
        end
        if (tx_dout !== 32'h0) report_mismatch("tx_dout", 32'h0, tx_dout);
    endtask

    task automatic reset_dut;
        slot = -1;
        comm_reset_detect = 1'b1;
        repeat (3) begin
            tick;
            check_reset_outputs;
        end
        comm_reset_detect = 1'b0;
        tick;
        if (tx_comm_init !== 1'b1) report_mismatch("tx_comm_init", 1, tx_comm_init);
        if (phy_state !== WAIT_WAKE) report_mismatch("phy_state", WAIT_WAKE, phy_state);
        tick;
        if (tx_comm_init !== 1'b0) report_mismatch("tx_comm_init", 0, tx_comm_init);
    endtask

    // Host side of OOB with an optional ALIGN answer
    task automatic bring_up(input logic send_align);
        int n;
        int wake_pulses;
        comm_wake_detect = 1'b1;
        tick;
        if (phy_state !== WAIT_NO_WAKE) report_mismatch("phy_state", WAIT_NO_WAKE, phy_state);
        repeat (2) tick;
        comm_wake_detect = 1'b0;
        wake_pulses = 0;
        repeat (6) begin
            tick;
            if (tx_comm_wake) wake_pulses++;
        end
        if (wake_pulses != 1) report_mismatch("tx_comm_wake pulses", 1, wake_pulses);
        if (phy_state !== WAIT_DIALTONE) report_mismatch("phy_state", WAIT_DIALTONE, phy_state);
        rx_din = `SATA_DIALTONE;
        rx_isk = 4'b0000;
        tick;
        rx_din = 32'h0;
        n = 0;
        while (!(tx_dout === `SATA_PRIM_ALIGN && tx_isk === 1'b1) && n < 8) begin
            tick;
            n++;
        end
        if (!(tx_dout === `SATA_PRIM_ALIGN && tx_isk === 1'b1)) begin
            report_failure("no ALIGN transmitted after dialtone");
        end
        if (tx_set_elec_idle !== 1'b0) report_mismatch("tx_set_elec_idle", 0, tx_set_elec_idle);
        if (send_align) begin
            rx_din = `SATA_PRIM_ALIGN;
            rx_isk = 4'b0001;
            tick;
            rx_din = 32'h0;
            rx_isk = 4'b0000;
            n = 0;
            while (phy_ready !== 1'b1 && n < 8) begin
                tick;
                n++;
            end
            if (phy_ready !== 1'b1) report_failure("phy_ready never rose after host ALIGN");
            if (hd_ready !== 1'b0) report_mismatch("hd_ready early", 0, hd_ready);
            slot = 0;
            tick;
            if (hd_ready !== 1'b1) report_mismatch("hd_ready", 1, hd_ready);
        end
    endtask

    task automatic send_rx_word(input logic [31:0] data, input logic [3:0] isk);
        rx_din = data;
        rx_isk = isk;
        tick;
        rx_din = 32'h0;
        rx_isk = 4'b0000;
    endtask

    task automatic wait_rx_req(input logic level);
        int n;
        n = 0;
        while (rx_req !== level && n < 6) begin
            tick;
            n++;
        end
        if (rx_req !== level) report_failure("rx_req did not reach the expected level");
    endtask

    task automatic run_row(input int i);
        int n;
        cur_test = row_name[i];
        if (row_in_align[i]) begin
            // Present the request at the first ALIGN slot
            while (((slot - 1) % ALIGN_INT) != ALIGN_INT - 3) tick;
        end
        tx_link_data  = row_tx_data[i];
        tx_link_isk   = row_tx_isk[i];
        link_exp_data = row_tx_data[i];
        link_exp_isk  = row_tx_isk[i];
        link_sent     = 1'b0;
        req_pending   = 1'b1;
        tx_req        = 1'b1;
        n = 0;
        while (tx_ack !== 1'b1 && n < 8) begin
            tick;
            n++;
        end
        req_pending = 1'b0;
        if (tx_ack !== 1'b1) report_failure("tx_ack never rose for the link request");
        if (!link_sent) report_failure("link dword was not transmitted");
        if (row_in_align[i] && ((slot - 1) % ALIGN_INT) != 0) begin
            report_mismatch("tx_ack slot", 0, (slot - 1) % ALIGN_INT);
        end
        tx_req = 1'b0;
        n = 0;
        while (tx_ack !== 1'b0 && n < 4) begin
            tick;
            n++;
        end
        if (tx_ack !== 1'b0) report_failure("tx_ack stayed high after tx_req dropped");

        send_rx_word(row_rx_data[i], row_rx_isk[i]);
        if (row_rx_offer[i]) begin
            wait_rx_req(1'b1);
            if (rx_prim_data !== row_rx_data[i]) begin
                report_mismatch("rx_prim_data", row_rx_data[i], rx_prim_data);
            end
            if (rx_prim_isk !== row_rx_isk[i]) begin
                report_mismatch("rx_prim_isk", row_rx_isk[i], rx_prim_isk);
            end
            rx_ack = 1'b1;
            wait_rx_req(1'b0);
            rx_ack = 1'b0;
            tick;
        end else begin
            repeat (4) begin
                tick;
                if (rx_req !== 1'b0) report_failure("word offered on the receive port");
            end
        end
    endtask

    task automatic check_overflow;
        cur_test = "rx_overflow";
        if (rx_overflow !== 1'b0) report_mismatch("rx_overflow before", 0, rx_overflow);
        send_rx_word(32'h3535B57C, 4'b0001);
        wait_rx_req(1'b1);
        // Second primitive while the first is still unacknowledged
        send_rx_word(32'h5656B57C, 4'b0001);
        repeat (3) tick;
        if (rx_overflow !== 1'b1) report_mismatch("rx_overflow", 1, rx_overflow);
        if (rx_prim_data !== 32'h3535B57C) begin
            report_mismatch("rx_prim_data", 32'h3535B57C, rx_prim_data);
        end
        rx_ack = 1'b1;
        wait_rx_req(1'b0);
        rx_ack = 1'b0;
        repeat (4) begin
            tick;
            if (rx_req !== 1'b0) report_failure("dropped primitive was offered later");
        end
        if (rx_overflow !== 1'b1) report_mismatch("rx_overflow sticky", 1, rx_overflow);
    endtask

    task automatic check_align_timeout;
        int n;
        cur_test = "align_timeout";
        reset_dut;
        bring_up(1'b0);
        n = 0;
        while (phy_state !== OFFLINE && n < `SATA_ALIGN_TIMEOUT + 10) begin
            tick;
            n++;
        end
        if (phy_state !== OFFLINE) report_failure("state did not go OFFLINE without host ALIGN");
        tick;
        repeat (20) begin
            tick;
            if (phy_state !== OFFLINE) report_mismatch("phy_state", OFFLINE, phy_state);
            if (tx_set_elec_idle !== 1'b1) begin
                report_mismatch("tx_set_elec_idle", 1, tx_set_elec_idle);
            end
            if (phy_ready !== 1'b0) report_mismatch("phy_ready", 0, phy_ready);
            if (tx_dout !== 32'h0) report_mismatch("tx_dout", 32'h0, tx_dout);
        end
    endtask

    initial begin
        int align_cnt;
        comm_reset_detect = 1'b1;
        comm_wake_detect  = 1'b0;
        rx_din            = 32'h0;
        rx_isk            = 4'b0000;
        tx_req            = 1'b0;
        tx_link_data      = 32'h0;
        tx_link_isk       = 1'b0;
        rx_ack            = 1'b0;
        error_count       = 0;
        lfsr_state        = 32'hfdfcb582;
        slot              = -1;
        req_pending       = 1'b0;
        link_sent         = 1'b0;
        cur_test          = "reset";
        build_table;

        reset_dut;
        cur_test = "oob_ready";
        bring_up(1'b1);

        // Any two full periods hold exactly four ALIGNs
        cur_test = "align_schedule";
        align_cnt = 0;
        repeat (2 * ALIGN_INT) begin
            tick;
            if (tx_dout === `SATA_PRIM_ALIGN) align_cnt++;
        end
        if (align_cnt != 4) report_mismatch("ALIGN count", 4, align_cnt);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        check_overflow;
        check_align_timeout;

        $display("Checks done with %0d errors", error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
sata_phy_pkg.sv
oob_ctrl.sv
rx_prim_detect.sv
tx_prim_gen.sv
faux_sata_dev_phy.sv
tb_faux_sata_dev_phy.sv
